//--- common/gpio_pkg.sv
////////////////////////////////////////////////////////////
// GPIO controller shared definitions
// pin count, APB register map, field positions in the
// register words and the vector types used across the block
////////////////////////////////////////////////////////////

package gpio_pkg;

   localparam int N_GPIO  = 32;  // pins handled by one controller
   localparam int NG_BITS = 5;   // bits needed to index one pin
   localparam int APB_AW  = 12;
   localparam int APB_DW  = 32;

   typedef logic [N_GPIO-1:0]  gpio_vec_t;  // one bit per pin
   typedef logic [NG_BITS-1:0] gpio_idx_t;
   typedef logic [APB_AW-1:0]  apb_addr_t;
   typedef logic [APB_DW-1:0]  apb_data_t;

   // register offsets
   localparam apb_addr_t REG_SETGPIO = 12'h000;  // set one pin, index in wdata
   localparam apb_addr_t REG_CLRGPIO = 12'h004;
   localparam apb_addr_t REG_TOGGPIO = 12'h008;
   localparam apb_addr_t REG_PIN0    = 12'h010;  // synchronized pad levels, read only
   localparam apb_addr_t REG_OUT0    = 12'h020;  // whole output word
   localparam apb_addr_t REG_SETSEL  = 12'h030;
   localparam apb_addr_t REG_RDSTAT  = 12'h034;  // status of the selected pin
   localparam apb_addr_t REG_SETDIR  = 12'h038;
   localparam apb_addr_t REG_SETINT  = 12'h03C;

   // direction field, bit 24 output enable and bit 25 open drain
   localparam int DIR_LSB = 24;

   // interrupt config field
   // fall and rise both clear selects a level interrupt
   localparam int INT_EN_BIT   = 16;
   localparam int INT_FALL_BIT = 17;
   localparam int INT_RISE_BIT = 18;
   localparam int INT_HIGH_BIT = 19;  // level polarity, 1 for active high

   // status word bits
   localparam int STAT_PIN_BIT = 12;
   localparam int STAT_OUT_BIT = 8;

endpackage

//--- common/gpio_irq_cfg_if.sv
////////////////////////////////////////////////////////////
// GPIO interrupt configuration interface
// carries the per-pin interrupt setup and pin levels from
// the register block to the interrupt unit
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface gpio_irq_cfg_if;

   gpio_pkg::gpio_vec_t irq_en;     // per-pin enable
   gpio_pkg::gpio_vec_t irq_fall;
   gpio_pkg::gpio_vec_t irq_rise;
   gpio_pkg::gpio_vec_t irq_high;   // level polarity
   gpio_pkg::gpio_vec_t pin_level;  // synchronized pad level

   modport cfg  (output irq_en, irq_fall, irq_rise, irq_high, pin_level);
   modport eval (input  irq_en, irq_fall, irq_rise, irq_high, pin_level);

endinterface

//--- gpio/gpio_in_sync.sv
////////////////////////////////////////////////////////////
// GPIO input synchronizer
// three flop chain for the asynchronous pad inputs, with
// registered rise and fall pulses aligned to the last stage
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module gpio_in_sync (
   input  logic                HCLK,
   input  logic                HRESETn,
   input  gpio_pkg::gpio_vec_t gpio_in,
   output gpio_pkg::gpio_vec_t pin_level,
   output gpio_pkg::gpio_vec_t pin_rise,
   output gpio_pkg::gpio_vec_t pin_fall
);

   gpio_pkg::gpio_vec_t sync0;  // metastability stages
   gpio_pkg::gpio_vec_t sync1;
   gpio_pkg::gpio_vec_t sync2;  // holding stage

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         sync0    <= '0;
         sync1    <= '0;
         sync2    <= '0;
         pin_rise <= '0;
         pin_fall <= '0;
      end else begin
         sync0    <= gpio_in;
         sync1    <= sync0;
         sync2    <= sync1;
         // compared before the last stage so the pulse lines up with it
         pin_rise <= sync1 & ~sync2;
         pin_fall <= ~sync1 & sync2;
      end
   end

   assign pin_level = sync2;

endmodule

//--- gpio/gpio_regs.sv
////////////////////////////////////////////////////////////
// GPIO APB register block
// decodes APB transfers with one wait state, holds output,
// direction, interrupt config and pin select, and builds
// the pad drive from the output and direction state
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module gpio_regs (
   input  logic                HCLK,
   input  logic                HRESETn,
   input  gpio_pkg::apb_addr_t PADDR,
   input  gpio_pkg::apb_data_t PWDATA,
   input  logic                PWRITE,
   input  logic                PSEL,
   input  logic                PENABLE,
   output gpio_pkg::apb_data_t PRDATA,
   output logic                PREADY,
   output logic                PSLVERR,
   input  gpio_pkg::gpio_vec_t pin_level,
   output gpio_pkg::gpio_vec_t gpio_out,
   output gpio_pkg::gpio_vec_t gpio_dir,
   gpio_irq_cfg_if.cfg         irq_cfg
);

   gpio_pkg::gpio_vec_t r_out;       // output register
   gpio_pkg::gpio_vec_t r_oe;        // direction mode, output enable
   gpio_pkg::gpio_vec_t r_od;        // direction mode, open drain
   gpio_pkg::gpio_vec_t r_irq_en;
   gpio_pkg::gpio_vec_t r_irq_fall;
   gpio_pkg::gpio_vec_t r_irq_rise;
   gpio_pkg::gpio_vec_t r_irq_high;
   gpio_pkg::gpio_idx_t r_sel;       // pin shown by RDSTAT
   gpio_pkg::gpio_idx_t wr_idx;
   gpio_pkg::apb_data_t rd_data;
   logic                access;
   logic                wr_err;
   logic                rd_err;

   // first access cycle only, PREADY closes the transfer on the next edge
   assign access = PSEL & PENABLE & ~PREADY;
   assign wr_idx = PWDATA[gpio_pkg::NG_BITS-1:0];

   // address decode, each offset is either write only, read only or both
   always_comb begin
      wr_err = 1'b1;
      rd_err = 1'b1;
      case (PADDR)
         gpio_pkg::REG_SETGPIO, gpio_pkg::REG_CLRGPIO, gpio_pkg::REG_TOGGPIO,
         gpio_pkg::REG_SETSEL, gpio_pkg::REG_SETDIR, gpio_pkg::REG_SETINT: begin
            wr_err = 1'b0;
         end
         gpio_pkg::REG_OUT0: begin
            wr_err = 1'b0;
            rd_err = 1'b0;
         end
         gpio_pkg::REG_PIN0, gpio_pkg::REG_RDSTAT: begin
            rd_err = 1'b0;
         end
         default: ;
      endcase
   end

   always_comb begin
      rd_data = '0;  // unmapped reads return zero
      case (PADDR)
         gpio_pkg::REG_PIN0: rd_data = pin_level;
         gpio_pkg::REG_OUT0: rd_data = r_out;
         gpio_pkg::REG_RDSTAT: begin
            rd_data[gpio_pkg::DIR_LSB+1:gpio_pkg::DIR_LSB] = {r_od[r_sel], r_oe[r_sel]};
            rd_data[gpio_pkg::INT_EN_BIT]   = r_irq_en[r_sel];
            rd_data[gpio_pkg::INT_FALL_BIT] = r_irq_fall[r_sel];
            rd_data[gpio_pkg::INT_RISE_BIT] = r_irq_rise[r_sel];
            rd_data[gpio_pkg::INT_HIGH_BIT] = r_irq_high[r_sel];
            rd_data[gpio_pkg::STAT_PIN_BIT] = pin_level[r_sel];
            rd_data[gpio_pkg::STAT_OUT_BIT] = r_out[r_sel];
            rd_data[gpio_pkg::NG_BITS-1:0]  = r_sel;
         end
         default: ;
      endcase
   end

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         PREADY     <= 1'b0;
         PSLVERR    <= 1'b0;
         PRDATA     <= '0;
         r_out      <= '0;
         r_oe       <= '0;
         r_od       <= '0;
         r_irq_en   <= '0;
         r_irq_fall <= '0;
         r_irq_rise <= '0;
         r_irq_high <= '0;
         r_sel      <= '0;
      end else begin
         PREADY  <= access;  // one cycle pulse
         PSLVERR <= access & (PWRITE ? wr_err : rd_err);
         if (access && !PWRITE) begin
            PRDATA <= rd_data;
         end
         if (access && PWRITE && !wr_err) begin
            case (PADDR)
               gpio_pkg::REG_SETGPIO: r_out[wr_idx] <= 1'b1;
               gpio_pkg::REG_CLRGPIO: r_out[wr_idx] <= 1'b0;
               gpio_pkg::REG_TOGGPIO: r_out[wr_idx] <= ~r_out[wr_idx];
               gpio_pkg::REG_OUT0:    r_out <= PWDATA;
               gpio_pkg::REG_SETDIR: begin
                  r_oe[wr_idx] <= PWDATA[gpio_pkg::DIR_LSB];
                  r_od[wr_idx] <= PWDATA[gpio_pkg::DIR_LSB+1];
               end
               gpio_pkg::REG_SETINT: begin
                  r_irq_en[wr_idx]   <= PWDATA[gpio_pkg::INT_EN_BIT];
                  r_irq_fall[wr_idx] <= PWDATA[gpio_pkg::INT_FALL_BIT];
                  r_irq_rise[wr_idx] <= PWDATA[gpio_pkg::INT_RISE_BIT];
                  r_irq_high[wr_idx] <= PWDATA[gpio_pkg::INT_HIGH_BIT];
               end
               default: ;
            endcase
            // every indexed write also moves the status select, OUT0 does not
            if (PADDR != gpio_pkg::REG_OUT0) begin
               r_sel <= wr_idx;
            end
         end
      end
   end

   // open drain only drives the pad while the output bit is low
   assign gpio_dir = (r_od & ~r_out) | (~r_od & r_oe);
   // value is only presented where the pad is actually driven
   assign gpio_out = r_oe & r_out & gpio_dir;

   assign irq_cfg.irq_en    = r_irq_en;
   assign irq_cfg.irq_fall  = r_irq_fall;
   assign irq_cfg.irq_rise  = r_irq_rise;
   assign irq_cfg.irq_high  = r_irq_high;
   assign irq_cfg.pin_level = pin_level;

endmodule

//--- gpio/gpio_irq.sv
////////////////////////////////////////////////////////////
// GPIO interrupt unit
// per-pin interrupt from edge pulses or pin level, gated
// by the enable and type set in the register block
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module gpio_irq (
   input  gpio_pkg::gpio_vec_t pin_rise,
   input  gpio_pkg::gpio_vec_t pin_fall,
   gpio_irq_cfg_if.eval        irq_cfg,
   output gpio_pkg::gpio_vec_t interrupt
);

   gpio_pkg::gpio_vec_t is_level;  // no edge type selected
   gpio_pkg::gpio_vec_t hit_fall;
   gpio_pkg::gpio_vec_t hit_rise;
   gpio_pkg::gpio_vec_t hit_level;

   always_comb begin
      is_level = ~irq_cfg.irq_fall & ~irq_cfg.irq_rise;

      // edge hits are one cycle wide, same as the sync pulses
      hit_fall = irq_cfg.irq_fall & pin_fall;
      hit_rise = irq_cfg.irq_rise & pin_rise;

      // level follows the synchronized pin, polarity from irq_high
      hit_level = is_level & ~(irq_cfg.pin_level ^ irq_cfg.irq_high);

      interrupt = irq_cfg.irq_en & (hit_fall | hit_rise | hit_level);
   end

endmodule

//--- gpio/apb_gpio.sv
////////////////////////////////////////////////////////////
// APB GPIO controller top level
// 32 pin controller joining the input synchronizer, the
// APB register block and the per-pin interrupt unit
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module apb_gpio (
   input  logic                HCLK,
   input  logic                HRESETn,
   input  gpio_pkg::apb_addr_t PADDR,
   input  gpio_pkg::apb_data_t PWDATA,
   input  logic                PWRITE,
   input  logic                PSEL,
   input  logic                PENABLE,
   output gpio_pkg::apb_data_t PRDATA,
   output logic                PREADY,
   output logic                PSLVERR,
   input  gpio_pkg::gpio_vec_t gpio_in,
   output gpio_pkg::gpio_vec_t gpio_in_sync,
   output gpio_pkg::gpio_vec_t gpio_out,
   output gpio_pkg::gpio_vec_t gpio_dir,
   output gpio_pkg::gpio_vec_t interrupt
);

   gpio_pkg::gpio_vec_t pin_level;
   gpio_pkg::gpio_vec_t pin_rise;
   gpio_pkg::gpio_vec_t pin_fall;

   gpio_irq_cfg_if irq_cfg ();  // regs to interrupt unit

   gpio_in_sync u_in_sync (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .gpio_in   (gpio_in),
      .pin_level (pin_level),
      .pin_rise  (pin_rise),
      .pin_fall  (pin_fall)
   );

   gpio_regs u_regs (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .PADDR     (PADDR),
      .PWDATA    (PWDATA),
      .PWRITE    (PWRITE),
      .PSEL      (PSEL),
      .PENABLE   (PENABLE),
      .PRDATA    (PRDATA),
      .PREADY    (PREADY),
      .PSLVERR   (PSLVERR),
      .pin_level (pin_level),
      .gpio_out  (gpio_out),
      .gpio_dir  (gpio_dir),
      .irq_cfg   (irq_cfg.cfg)
   );

   gpio_irq u_irq (
      .pin_rise  (pin_rise),
      .pin_fall  (pin_fall),
      .irq_cfg   (irq_cfg.eval),
      .interrupt (interrupt)
   );

   assign gpio_in_sync = pin_level;

endmodule

//--- tests/apb_gpio_checker.sv
////////////////////////////////////////////////////////////
// APB GPIO protocol and pad checker
// concurrent assertions on the APB handshake, pad drive and
// rising edge interrupt timing, bound into the top level
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module apb_gpio_checker (
   input logic                HCLK,
   input logic                HRESETn,
   input logic                PSEL,
   input logic                PENABLE,
   input logic                PREADY,
   input logic                PSLVERR,
   input gpio_pkg::gpio_vec_t gpio_in_sync,
   input gpio_pkg::gpio_vec_t gpio_out,
   input gpio_pkg::gpio_vec_t gpio_dir,
   input gpio_pkg::gpio_vec_t interrupt,
   input gpio_pkg::gpio_vec_t irq_en,
   input gpio_pkg::gpio_vec_t irq_fall,
   input gpio_pkg::gpio_vec_t irq_rise
);

   gpio_pkg::gpio_vec_t rise_mask;  // enabled pins with rise only

   assign rise_mask = irq_en & irq_rise & ~irq_fall;

   ready_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn)
      PREADY |=> !PREADY) else $error("PREADY high two cycles");
   ready_cause: assert property (@(posedge HCLK) disable iff (!HRESETn)
      PREADY |-> $past(PSEL && PENABLE)) else $error("PREADY without access");
   err_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
      PSLVERR |-> PREADY) else $error("PSLVERR without PREADY");
   out_driven: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (gpio_out & ~gpio_dir) == '0) else $error("gpio_out on undriven pad");
   rise_irq: assert property (@(posedge HCLK) disable iff (!HRESETn)
      ((interrupt ^ (gpio_in_sync & ~$past(gpio_in_sync))) & rise_mask) == '0)
      else $error("rise interrupt mismatch");

endmodule

bind apb_gpio apb_gpio_checker chk_i (
   .HCLK         (HCLK),
   .HRESETn      (HRESETn),
   .PSEL         (PSEL),
   .PENABLE      (PENABLE),
   .PREADY       (PREADY),
   .PSLVERR      (PSLVERR),
   .gpio_in_sync (gpio_in_sync),
   .gpio_out     (gpio_out),
   .gpio_dir     (gpio_dir),
   .interrupt    (interrupt),
   .irq_en       (irq_cfg.irq_en),
   .irq_fall     (irq_cfg.irq_fall),
   .irq_rise     (irq_cfg.irq_rise)
);

//--- tests/tb_apb_gpio.sv
////////////////////////////////////////////////////////////
// APB GPIO controller testbench
// directed and random APB traffic, pad input stimulus and
// interrupt checks against a small register model
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_apb_gpio;

   localparam int CLK_PERIOD = 40;
   localparam int N_TESTS    = 5;
   localparam int TEST_CYC   = 200;  // cycle budget per test

   logic                HCLK;
   logic                HRESETn;
   gpio_pkg::apb_addr_t PADDR;
   gpio_pkg::apb_data_t PWDATA;
   logic                PWRITE;
   logic                PSEL;
   logic                PENABLE;
   gpio_pkg::apb_data_t PRDATA;
   logic                PREADY;
   logic                PSLVERR;
   gpio_pkg::gpio_vec_t gpio_in;
   gpio_pkg::gpio_vec_t gpio_in_sync;
   gpio_pkg::gpio_vec_t gpio_out;
   gpio_pkg::gpio_vec_t gpio_dir;
   gpio_pkg::gpio_vec_t interrupt;

   // model state
   gpio_pkg::gpio_vec_t in_m;
   gpio_pkg::gpio_vec_t out_m;
   gpio_pkg::gpio_vec_t oe_m;
   gpio_pkg::gpio_vec_t od_m;
   int err_cnt;
   int check_cnt;
   int test_err;

   apb_gpio dut_i (.*);

   always #(CLK_PERIOD/2) HCLK = ~HCLK;

   initial begin
      #(N_TESTS * TEST_CYC * CLK_PERIOD);
      $display("watchdog expired, the run did not complete in time");
      $display("*** FAILED ***");
      $finish;
   end

   task automatic check_word(input string what, input gpio_pkg::apb_data_t got,
                             input gpio_pkg::apb_data_t exp);
      check_cnt++;
      assert (got === exp) else begin
         $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic apb_xfer(input logic wr, input gpio_pkg::apb_addr_t addr,
                           input gpio_pkg::apb_data_t wdata,
                           output gpio_pkg::apb_data_t rdata, output logic err);
      int waited;
      waited = 0;
      @(posedge HCLK);
      PSEL    <= 1'b1;   // setup phase
      PWRITE  <= wr;
      PADDR   <= addr;
      PWDATA  <= wdata;
      PENABLE <= 1'b0;
      @(posedge HCLK);
      PENABLE <= 1'b1;
      do begin
         @(posedge HCLK);
         waited++;
      end while (PREADY !== 1'b1 && waited < 8);
      if (PREADY !== 1'b1) begin
         $display("APB transfer to %h never saw PREADY", addr);
         err_cnt++;
      end
      rdata = PRDATA;
      err   = PSLVERR;
      PSEL    <= 1'b0;
      PENABLE <= 1'b0;
   endtask

   task automatic apb_write(input gpio_pkg::apb_addr_t addr, input gpio_pkg::apb_data_t data);
      gpio_pkg::apb_data_t rd;
      logic                err;
      apb_xfer(1'b1, addr, data, rd, err);
      check_word("write PSLVERR", {31'd0, err}, 32'd0);
   endtask

   task automatic apb_read(input gpio_pkg::apb_addr_t addr, output gpio_pkg::apb_data_t data);
      logic err;
      apb_xfer(1'b0, addr, '0, data, err);
      check_word("read PSLVERR", {31'd0, err}, 32'd0);
   endtask

   task automatic end_test(input string name);
      $display("test %-12s done, %0d errors", name, err_cnt - test_err);
      test_err = err_cnt;
   endtask

   // pad enable per pin, open drain follows the inverted output bit
   function automatic gpio_pkg::gpio_vec_t exp_dir();
      gpio_pkg::gpio_vec_t e;
      for (int i = 0; i < gpio_pkg::N_GPIO; i++) begin
         e[i] = od_m[i] ? ~out_m[i] : oe_m[i];
      end
      return e;
   endfunction

   // pad value per pin, an open drain pad only ever pulls low
   function automatic gpio_pkg::gpio_vec_t exp_out();
      gpio_pkg::gpio_vec_t e;
      for (int i = 0; i < gpio_pkg::N_GPIO; i++) begin
         e[i] = (oe_m[i] && !od_m[i]) ? out_m[i] : 1'b0;
      end
      return e;
   endfunction

   // pin0 rise, pin1 fall, pin2 high level, pin3 low level, pin4 disabled
   function automatic gpio_pkg::gpio_vec_t exp_irq(input gpio_pkg::gpio_vec_t prev,
                                                 input gpio_pkg::gpio_vec_t cur);
      gpio_pkg::gpio_vec_t e;
      e    = '0;
      e[0] = cur[0] & ~prev[0];
      e[1] = ~cur[1] & prev[1];
      e[2] = cur[2];
      e[3] = ~cur[3];
      return e;
   endfunction

   initial begin
      gpio_pkg::apb_data_t rd;
      gpio_pkg::apb_data_t d;
      gpio_pkg::gpio_vec_t prev;
      gpio_pkg::gpio_idx_t idx;
      gpio_pkg::apb_addr_t wo_addr[6];  // write only offsets
      logic                err;
      logic                bit_v;
      int                  op;

      void'($urandom(28121));
      HCLK = 1'b0;
      HRESETn = 1'b0;
      PADDR = '0;
      PWDATA = '0;
      PWRITE = 1'b0;
      PSEL = 1'b0;
      PENABLE = 1'b0;
      gpio_in = '0;
      in_m = '0;
      out_m = '0;
      oe_m = '0;
      od_m = '0;
      err_cnt = 0;
      check_cnt = 0;
      test_err = 0;
      wo_addr = '{gpio_pkg::REG_SETGPIO, gpio_pkg::REG_CLRGPIO, gpio_pkg::REG_TOGGPIO,
                  gpio_pkg::REG_SETSEL, gpio_pkg::REG_SETDIR, gpio_pkg::REG_SETINT};
      repeat (2) @(posedge HCLK);
      HRESETn <= 1'b1;

      // output registers, all pins push-pull
      for (int i = 0; i < gpio_pkg::N_GPIO; i++) begin
         apb_write(gpio_pkg::REG_SETDIR, (32'd1 << gpio_pkg::DIR_LSB) | i);
      end
      oe_m = '1;
      for (int n = 0; n < 16; n++) begin
         idx = gpio_pkg::gpio_idx_t'($urandom);
         op  = n < 3 ? 3 : int'($urandom % 4);
         case (op)
            0: begin
               apb_write(gpio_pkg::REG_SETGPIO, {27'd0, idx});
               out_m[idx] = 1'b1;
            end
            1: begin
               apb_write(gpio_pkg::REG_CLRGPIO, {27'd0, idx});
               out_m[idx] = 1'b0;
            end
            2: begin
               apb_write(gpio_pkg::REG_TOGGPIO, {27'd0, idx});
               out_m[idx] = ~out_m[idx];
            end
            default: begin
               out_m = $urandom;
               apb_write(gpio_pkg::REG_OUT0, out_m);
            end
         endcase
         apb_read(gpio_pkg::REG_OUT0, rd);
         check_word("OUT0 read", rd, out_m);
         check_word("gpio_out", gpio_out, out_m);
         check_word("gpio_dir", gpio_dir, '1);
      end
      end_test("output");

      // input path, three flop latency
      for (int n = 0; n < 6; n++) begin
         @(posedge HCLK);
         prev = in_m;
         in_m = $urandom;
         gpio_in <= in_m;
         repeat (2) @(posedge HCLK);
         @(negedge HCLK);
         check_word("gpio_in_sync early", gpio_in_sync, prev);
         @(posedge HCLK);
         @(negedge HCLK);
         check_word("gpio_in_sync", gpio_in_sync, in_m);
         apb_read(gpio_pkg::REG_PIN0, rd);
         check_word("PIN0 read", rd, in_m);
      end
      end_test("input");

      // direction modes and status, first two are open drain high and low
      for (int n = 0; n < 6; n++) begin
         idx = gpio_pkg::gpio_idx_t'($urandom);
         d = '0;
         d[gpio_pkg::DIR_LSB]   = n < 2 ? 1'b1 : 1'($urandom);
         d[gpio_pkg::DIR_LSB+1] = n < 2 ? 1'b1 : 1'($urandom);
         d[4:0] = idx;
         bit_v = n < 2 ? n[0] : 1'($urandom);
         apb_write(gpio_pkg::REG_SETDIR, d);
         oe_m[idx] = d[gpio_pkg::DIR_LSB];
         od_m[idx] = d[gpio_pkg::DIR_LSB+1];
         apb_write(bit_v ? gpio_pkg::REG_SETGPIO : gpio_pkg::REG_CLRGPIO, {27'd0, idx});
         out_m[idx] = bit_v;
         check_word("gpio_dir mode", gpio_dir, exp_dir());
         check_word("gpio_out mode", gpio_out, exp_out());
         d = '0;
         d[gpio_pkg::DIR_LSB]      = oe_m[idx];
         d[gpio_pkg::DIR_LSB+1]    = od_m[idx];
         d[gpio_pkg::STAT_PIN_BIT] = in_m[idx];
         d[gpio_pkg::STAT_OUT_BIT] = out_m[idx];
         d[4:0] = idx;
         apb_read(gpio_pkg::REG_RDSTAT, rd);
         check_word("RDSTAT read", rd, d);
      end
      end_test("direction");

      // interrupts on pins 0 to 4
      @(posedge HCLK);
      in_m[4:0] = '0;
      gpio_in <= in_m;
      repeat (4) @(posedge HCLK);
      apb_write(gpio_pkg::REG_SETINT, 32'h0005_0000);  // rise
      apb_write(gpio_pkg::REG_SETINT, 32'h0003_0001);  // fall
      apb_write(gpio_pkg::REG_SETINT, 32'h0009_0002);  // high level
      apb_write(gpio_pkg::REG_SETINT, 32'h0001_0003);  // low level
      apb_write(gpio_pkg::REG_SETINT, 32'h0004_0004);  // rise, not enabled
      for (int n = 0; n < 8; n++) begin
         @(posedge HCLK);
         prev = in_m;
         in_m[4:0] = n[0] ? 5'h00 : 5'h1F;
         if (n > 3) in_m[4:0] = 5'($urandom);
         gpio_in <= in_m;
         repeat (2) @(posedge HCLK);
         @(negedge HCLK);
         check_word("interrupt before", interrupt, exp_irq(prev, prev));
         @(posedge HCLK);
         @(negedge HCLK);
         check_word("interrupt edge", interrupt, exp_irq(prev, in_m));
         @(posedge HCLK);
         @(negedge HCLK);
         check_word("interrupt after", interrupt, exp_irq(in_m, in_m));
      end
      end_test("interrupt");

      // bus errors, no state change
      foreach (wo_addr[i]) begin
         apb_xfer(1'b0, wo_addr[i], '0, rd, err);
         check_word($sformatf("read %h err", wo_addr[i]), {31'd0, err}, 32'd1);
      end
      apb_xfer(1'b1, gpio_pkg::REG_PIN0, $urandom, rd, err);
      check_word("write PIN0 err", {31'd0, err}, 32'd1);
      apb_xfer(1'b1, gpio_pkg::REG_RDSTAT, $urandom, rd, err);
      check_word("write RDSTAT err", {31'd0, err}, 32'd1);
      apb_read(gpio_pkg::REG_OUT0, rd);
      check_word("OUT0 after errors", rd, out_m);
      check_word("gpio_dir after errors", gpio_dir, exp_dir());
      end_test("bus error");

      $display("tests %0d, checks %0d, errors %0d", N_TESTS, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- src.f
common/gpio_pkg.sv
common/gpio_irq_cfg_if.sv
gpio/gpio_in_sync.sv
gpio/gpio_regs.sv
gpio/gpio_irq.sv
gpio/apb_gpio.sv
tests/apb_gpio_checker.sv
tests/tb_apb_gpio.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_apb_gpio
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
